// ==== common/fe2_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared types for the Fp2 multiplication engine
// field prime, element typedefs, modular add and subtract
////////////////////////////////////////////////////////////////////////////

package fe2_pkg;

localparam int FE_BITS = 32;

typedef logic [FE_BITS-1:0]   fe_t;        // one Fp element
typedef logic [2*FE_BITS-1:0] fe2_t;       // {c1, c0}
typedef logic [2*FE_BITS-1:0] fe_wide_t;   // unreduced product
typedef logic [7:0]           tag_t;       // caller job tag
typedef logic [1:0]           prod_idx_t;  // 0 a0b0, 1 a1b1, 2 a0b1, 3 a1b0

// 2^32 - 5, congruent to 3 mod 4 so u^2 + 1 is irreducible
localparam fe_t P = 32'd4294967291;

// a + b mod P, both inputs below P
function automatic fe_t fe_add(fe_t a, fe_t b);
  logic [FE_BITS:0] s;
  s = {1'b0, a} + {1'b0, b};
  if (s >= {1'b0, P}) begin
    s = s - {1'b0, P};
  end
  return s[FE_BITS-1:0];
endfunction

// a - b mod P, both inputs below P
function automatic fe_t fe_sub(fe_t a, fe_t b);
  fe_t d;
  d = a - b;
  if (a < b) begin
    d = d + P;  // wraps back into range
  end
  return d;
endfunction

endpackage

// ==== design/mul_share/fe_mul_pipe.sv ====
////////////////////////////////////////////////////////////////////////////
// pipelined modular multiplier, a * b mod P
// control bits travel alongside, whole pipe freezes on stall
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fe_mul_pipe #(
  parameter int MUL_LEVEL = 3,
  parameter int CTL_BITS  = 4
)(
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_val,
  output logic                o_rdy,
  input  fe2_pkg::fe_t        i_a,
  input  fe2_pkg::fe_t        i_b,
  input  logic [CTL_BITS-1:0] i_ctl,
  output logic                o_val,
  input  logic                i_rdy,
  output fe2_pkg::fe_t        o_res,
  output logic [CTL_BITS-1:0] o_ctl
);

import fe2_pkg::*;

// 2^32 mod P, small enough that two folds plus one subtract reduce fully
localparam logic [FE_BITS+2:0] FOLD = {3'b001, {FE_BITS{1'b0}}} - {3'b000, P};

function automatic fe_t fe_reduce(fe_wide_t x);
  logic [FE_BITS+2:0] hi;
  logic [FE_BITS+2:0] lo;
  logic [FE_BITS+2:0] t;
  hi = {3'b000, x[2*FE_BITS-1:FE_BITS]};
  lo = {3'b000, x[FE_BITS-1:0]};
  t  = hi * FOLD + lo;  // below 6 * 2^32
  hi = {{FE_BITS{1'b0}}, t[FE_BITS+2:FE_BITS]};
  lo = {3'b000, t[FE_BITS-1:0]};
  t  = hi * FOLD + lo;  // below 2^32 + 30
  if (t >= {3'b000, P}) begin
    t = t - {3'b000, P};
  end
  return t[FE_BITS-1:0];
endfunction

logic [MUL_LEVEL-1:0] val_q;
fe_wide_t             prod_q [MUL_LEVEL];
logic [CTL_BITS-1:0]  ctl_q  [MUL_LEVEL];

assign o_rdy = !val_q[MUL_LEVEL-1] || i_rdy;  // last stage empty or draining
assign o_val = val_q[MUL_LEVEL-1];
assign o_res = fe_reduce(prod_q[MUL_LEVEL-1]);
assign o_ctl = ctl_q[MUL_LEVEL-1];

always_ff @(posedge i_clk or negedge i_rst_n) begin
  if (!i_rst_n) begin
    val_q <= '0;
  end else if (o_rdy) begin
    val_q[0] <= i_val;
    for (int i = 1; i < MUL_LEVEL; i++) val_q[i] <= val_q[i-1];
  end
end

always_ff @(posedge i_clk) begin
  if (o_rdy) begin
    prod_q[0] <= fe_wide_t'(i_a) * fe_wide_t'(i_b);
    ctl_q[0]  <= i_ctl;
    for (int i = 1; i < MUL_LEVEL; i++) begin
      prod_q[i] <= prod_q[i-1];
      ctl_q[i]  <= ctl_q[i-1];
    end
  end
end

assert property (@(posedge i_clk) disable iff (!i_rst_n)
  (o_val && !i_rdy) |=> o_val && $stable(o_res) && $stable(o_ctl))
  else $error("multiplier output changed while stalled");

endmodule

// ==== design/mul_share/mul_share_arb.sv ====
////////////////////////////////////////////////////////////////////////////
// round-robin share of one multiplier between the lanes
// lane index rides in the control bits and routes the result back
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mul_share_arb #(
  parameter int NUM_LANES = 4
)(
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic [NUM_LANES-1:0]                i_req_val,
  output logic [NUM_LANES-1:0]                o_req_rdy,
  input  fe2_pkg::fe_t [NUM_LANES-1:0]        i_req_x,
  input  fe2_pkg::fe_t [NUM_LANES-1:0]        i_req_y,
  input  fe2_pkg::prod_idx_t [NUM_LANES-1:0]  i_req_idx,
  output logic                                o_mul_val,
  input  logic                                i_mul_rdy,
  output fe2_pkg::fe_t                        o_mul_a,
  output fe2_pkg::fe_t                        o_mul_b,
  output logic [$clog2(NUM_LANES)+1:0]        o_mul_ctl,
  input  logic                                i_res_val,
  input  fe2_pkg::fe_t                        i_res,
  input  logic [$clog2(NUM_LANES)+1:0]        i_res_ctl,
  output logic [NUM_LANES-1:0]                o_ret_val,
  output fe2_pkg::fe_t                        o_ret_res,
  output fe2_pkg::prod_idx_t                  o_ret_idx
);

localparam int LANE_BITS = $clog2(NUM_LANES);

logic [LANE_BITS-1:0] ptr_q;  // highest priority lane
logic [LANE_BITS-1:0] sel;
logic                 found;
logic [NUM_LANES-1:0] grant;

// a lane is ready when no lane ahead of it in the rotation requests,
// so its own val never feeds its rdy
always_comb begin
  int idx;
  found     = 1'b0;
  sel       = ptr_q;
  o_req_rdy = '0;
  for (int k = 0; k < NUM_LANES; k++) begin
    idx = int'(ptr_q) + k;
    if (idx >= NUM_LANES) begin
      idx = idx - NUM_LANES;
    end
    o_req_rdy[idx] = i_mul_rdy && !found;
    if (!found && i_req_val[idx]) begin
      found = 1'b1;
      sel   = LANE_BITS'(idx);
    end
  end
end

assign grant     = i_req_val & o_req_rdy;
assign o_mul_val = found;
assign o_mul_a   = i_req_x[sel];
assign o_mul_b   = i_req_y[sel];
assign o_mul_ctl = {sel, i_req_idx[sel]};  // lane above product index

// result goes only to the lane named in the control
always_comb begin
  for (int i = 0; i < NUM_LANES; i++) begin
    o_ret_val[i] = i_res_val && (i_res_ctl[LANE_BITS+1:2] == LANE_BITS'(i));
  end
end

assign o_ret_res = i_res;
assign o_ret_idx = i_res_ctl[1:0];

always_ff @(posedge i_clk or negedge i_rst_n) begin
  if (!i_rst_n) begin
    ptr_q <= '0;
  end else if (o_mul_val && i_mul_rdy) begin
    ptr_q <= (sel == LANE_BITS'(NUM_LANES - 1)) ? '0 : sel + 1'b1;
  end
end

// at most one lane transfers per cycle
assert property (@(posedge i_clk) disable iff (!i_rst_n)
  $onehot0(grant))
  else $error("arbiter grant not one-hot");

endmodule

// ==== design/fe2_dispatch.sv ====
////////////////////////////////////////////////////////////////////////////
// job dispatcher, hands each Fp2 job to an idle lane
// round-robin search starting at a rotating pointer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fe2_dispatch #(
  parameter int NUM_LANES = 4
)(
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_val,
  output logic                 o_rdy,
  input  fe2_pkg::fe2_t        i_a,
  input  fe2_pkg::fe2_t        i_b,
  input  fe2_pkg::tag_t        i_tag,
  output logic [NUM_LANES-1:0] o_lane_val,
  input  logic [NUM_LANES-1:0] i_lane_rdy,
  output fe2_pkg::fe2_t        o_a,
  output fe2_pkg::fe2_t        o_b,
  output fe2_pkg::tag_t        o_tag
);

localparam int LANE_BITS = $clog2(NUM_LANES);

logic [LANE_BITS-1:0] ptr_q;  // first lane to try
logic [LANE_BITS-1:0] sel;    // chosen lane
logic                 found;

always_comb begin
  int idx;
  found      = 1'b0;
  sel        = ptr_q;
  o_lane_val = '0;
  for (int k = 0; k < NUM_LANES; k++) begin
    idx = int'(ptr_q) + k;
    if (idx >= NUM_LANES) begin
      idx = idx - NUM_LANES;  // wrap around
    end
    if (!found && i_lane_rdy[idx]) begin
      found           = 1'b1;
      sel             = LANE_BITS'(idx);
      o_lane_val[idx] = i_val;
    end
  end
end

assign o_rdy = |i_lane_rdy;  // any idle lane
assign o_a   = i_a;          // shared operand bus
assign o_b   = i_b;
assign o_tag = i_tag;

always_ff @(posedge i_clk or negedge i_rst_n) begin
  if (!i_rst_n) begin
    ptr_q <= '0;
  end else if (i_val && found) begin
    ptr_q <= (sel == LANE_BITS'(NUM_LANES - 1)) ? '0 : sel + 1'b1;  // past chosen lane
  end
end

endmodule

// ==== design/fe2_mul_lane.sv ====
////////////////////////////////////////////////////////////////////////////
// one Fp2 multiplication lane
// issues four base-field products, then combines them mod P
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fe2_mul_lane (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_val,
  output logic               o_rdy,
  input  fe2_pkg::fe2_t      i_a,
  input  fe2_pkg::fe2_t      i_b,
  input  fe2_pkg::tag_t      i_tag,
  output logic               o_req_val,
  input  logic               i_req_rdy,
  output fe2_pkg::fe_t       o_req_x,
  output fe2_pkg::fe_t       o_req_y,
  output fe2_pkg::prod_idx_t o_req_idx,
  input  logic               i_ret_val,
  input  fe2_pkg::fe_t       i_ret_res,
  input  fe2_pkg::prod_idx_t i_ret_idx,
  output logic               o_done_val,
  input  logic               i_done_rdy,
  output fe2_pkg::fe2_t      o_res,
  output fe2_pkg::tag_t      o_tag
);

import fe2_pkg::*;

typedef enum logic [1:0] {st_idle, st_issue, st_wait, st_done} state_t;

state_t     state_q;
prod_idx_t  iss_q;      // next product to issue
logic [2:0] ret_cnt_q;  // products returned so far
fe2_t       a_q;
fe2_t       b_q;
tag_t       tag_q;
fe_t        p_q [4];    // slot per prod_idx_t
fe2_t       res_q;
logic       take_job;
logic       issue_ok;
logic       combine;

assign take_job = i_val && o_rdy;
assign issue_ok = o_req_val && i_req_rdy;
assign combine  = (state_q == st_wait) && (ret_cnt_q == 3'd4);

assign o_rdy     = (state_q == st_idle);
assign o_req_val = (state_q == st_issue);
assign o_req_idx = iss_q;
// x takes a1 for indices 1 and 3, y takes b1 for indices 1 and 2
assign o_req_x   = iss_q[0] ? a_q[2*FE_BITS-1:FE_BITS] : a_q[FE_BITS-1:0];
assign o_req_y   = (iss_q[0] ^ iss_q[1]) ? b_q[2*FE_BITS-1:FE_BITS] : b_q[FE_BITS-1:0];

assign o_done_val = (state_q == st_done);
assign o_res      = res_q;
assign o_tag      = tag_q;

always_ff @(posedge i_clk or negedge i_rst_n) begin
  if (!i_rst_n) begin
    state_q   <= st_idle;
    iss_q     <= '0;
    ret_cnt_q <= '0;
  end else begin
    if (take_job) begin
      ret_cnt_q <= '0;
    end else if (i_ret_val) begin
      ret_cnt_q <= ret_cnt_q + 3'd1;
    end
    case (state_q)
      st_idle: begin
        if (take_job) begin
          state_q <= st_issue;
          iss_q   <= '0;
        end
      end
      st_issue: begin
        if (issue_ok) begin
          iss_q <= iss_q + 2'd1;
          if (iss_q == 2'd3) state_q <= st_wait;  // all four sent
        end
      end
      st_wait: if (combine) state_q <= st_done;
      st_done: if (i_done_rdy) state_q <= st_idle;
      default: state_q <= st_idle;
    endcase
  end
end

always_ff @(posedge i_clk) begin
  if (take_job) begin
    a_q   <= i_a;
    b_q   <= i_b;
    tag_q <= i_tag;
  end
  if (i_ret_val) p_q[i_ret_idx] <= i_ret_res;
  // c1 = a0b1 + a1b0, c0 = a0b0 - a1b1
  if (combine) res_q <= {fe_add(p_q[2], p_q[3]), fe_sub(p_q[0], p_q[1])};
end

// products only come back to a busy lane, and the shared multiplier reduces them
assert property (@(posedge i_clk) disable iff (!i_rst_n)
  i_ret_val |-> (i_ret_res < P) && (state_q inside {st_issue, st_wait}))
  else $error("lane return out of range or unexpected");

assert property (@(posedge i_clk) disable iff (!i_rst_n)
  o_done_val |-> (o_res[FE_BITS-1:0] < P) && (o_res[2*FE_BITS-1:FE_BITS] < P))
  else $error("lane result not reduced");

endmodule

// ==== design/fe2_collect.sv ====
////////////////////////////////////////////////////////////////////////////
// result collector, drains finished lanes to one output stream
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fe2_collect #(
  parameter int NUM_LANES = 4
)(
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic [NUM_LANES-1:0]           i_done_val,
  output logic [NUM_LANES-1:0]           o_done_rdy,
  input  fe2_pkg::fe2_t [NUM_LANES-1:0]  i_lane_res,
  input  fe2_pkg::tag_t [NUM_LANES-1:0]  i_lane_tag,
  output logic                           o_val,
  input  logic                           i_rdy,
  output fe2_pkg::fe2_t                  o_res,
  output fe2_pkg::tag_t                  o_tag
);

localparam int LANE_BITS = $clog2(NUM_LANES);

logic [LANE_BITS-1:0] ptr_q;
logic [LANE_BITS-1:0] sel;
logic                 found;

always_comb begin
  int idx;
  found      = 1'b0;
  sel        = ptr_q;
  o_done_rdy = '0;
  for (int k = 0; k < NUM_LANES; k++) begin
    idx = int'(ptr_q) + k;
    if (idx >= NUM_LANES) begin
      idx = idx - NUM_LANES;
    end
    o_done_rdy[idx] = i_rdy && !found;  // blocked by an earlier done lane
    if (!found && i_done_val[idx]) begin
      found = 1'b1;
      sel   = LANE_BITS'(idx);
    end
  end
end

assign o_val = found;
assign o_res = i_lane_res[sel];
assign o_tag = i_lane_tag[sel];

// parking the pointer on the held lane keeps the choice while stalled
always_ff @(posedge i_clk or negedge i_rst_n) begin
  if (!i_rst_n) begin
    ptr_q <= '0;
  end else if (o_val) begin
    if (!i_rdy) ptr_q <= sel;
    else ptr_q <= (sel == LANE_BITS'(NUM_LANES - 1)) ? '0 : sel + 1'b1;
  end
end

endmodule

// ==== design/fe2_mul_engine.sv ====
////////////////////////////////////////////////////////////////////////////
// Fp2 multiplication engine top level
// dispatcher, lanes, shared multiplier and collector
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fe2_mul_engine #(
  parameter int NUM_LANES = 4,
  parameter int MUL_LEVEL = 3
)(
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_val,
  output logic          o_rdy,
  input  fe2_pkg::fe2_t i_a,
  input  fe2_pkg::fe2_t i_b,
  input  fe2_pkg::tag_t i_tag,
  output logic          o_val,
  input  logic          i_rdy,
  output fe2_pkg::fe2_t o_res,
  output fe2_pkg::tag_t o_tag
);

import fe2_pkg::*;

localparam int LANE_BITS = $clog2(NUM_LANES);
localparam int CTL_BITS  = LANE_BITS + 2;  // lane index above prod_idx_t

logic [NUM_LANES-1:0]      lane_val;
logic [NUM_LANES-1:0]      lane_rdy;
fe2_t                      disp_a;
fe2_t                      disp_b;
tag_t                      disp_tag;
logic [NUM_LANES-1:0]      req_val;
logic [NUM_LANES-1:0]      req_rdy;
fe_t [NUM_LANES-1:0]       req_x;
fe_t [NUM_LANES-1:0]       req_y;
prod_idx_t [NUM_LANES-1:0] req_idx;
logic                      mul_val;
logic                      mul_rdy;
fe_t                       mul_a;
fe_t                       mul_b;
logic [CTL_BITS-1:0]       mul_ctl;
logic                      res_val;
fe_t                       res;
logic [CTL_BITS-1:0]       res_ctl;
logic [NUM_LANES-1:0]      ret_val;
fe_t                       ret_res;
prod_idx_t                 ret_idx;
logic [NUM_LANES-1:0]      done_val;
logic [NUM_LANES-1:0]      done_rdy;
fe2_t [NUM_LANES-1:0]      lane_res;
tag_t [NUM_LANES-1:0]      lane_tag;

fe2_dispatch #(.NUM_LANES(NUM_LANES)) fe2_dispatch (
  .i_clk(i_clk), .i_rst_n(i_rst_n),
  .i_val(i_val), .o_rdy(o_rdy), .i_a(i_a), .i_b(i_b), .i_tag(i_tag),
  .o_lane_val(lane_val), .i_lane_rdy(lane_rdy),
  .o_a(disp_a), .o_b(disp_b), .o_tag(disp_tag)
);

for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
  fe2_mul_lane fe2_mul_lane (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_val(lane_val[i]), .o_rdy(lane_rdy[i]),
    .i_a(disp_a), .i_b(disp_b), .i_tag(disp_tag),
    .o_req_val(req_val[i]), .i_req_rdy(req_rdy[i]),
    .o_req_x(req_x[i]), .o_req_y(req_y[i]), .o_req_idx(req_idx[i]),
    .i_ret_val(ret_val[i]), .i_ret_res(ret_res), .i_ret_idx(ret_idx),
    .o_done_val(done_val[i]), .i_done_rdy(done_rdy[i]),
    .o_res(lane_res[i]), .o_tag(lane_tag[i])
  );
end

mul_share_arb #(.NUM_LANES(NUM_LANES)) mul_share_arb (
  .i_clk(i_clk), .i_rst_n(i_rst_n),
  .i_req_val(req_val), .o_req_rdy(req_rdy),
  .i_req_x(req_x), .i_req_y(req_y), .i_req_idx(req_idx),
  .o_mul_val(mul_val), .i_mul_rdy(mul_rdy),
  .o_mul_a(mul_a), .o_mul_b(mul_b), .o_mul_ctl(mul_ctl),
  .i_res_val(res_val), .i_res(res), .i_res_ctl(res_ctl),
  .o_ret_val(ret_val), .o_ret_res(ret_res), .o_ret_idx(ret_idx)
);

fe_mul_pipe #(.MUL_LEVEL(MUL_LEVEL), .CTL_BITS(CTL_BITS)) fe_mul_pipe (
  .i_clk(i_clk), .i_rst_n(i_rst_n),
  .i_val(mul_val), .o_rdy(mul_rdy), .i_a(mul_a), .i_b(mul_b), .i_ctl(mul_ctl),
  .o_val(res_val), .i_rdy(1'b1),  // lanes always accept results
  .o_res(res), .o_ctl(res_ctl)
);

fe2_collect #(.NUM_LANES(NUM_LANES)) fe2_collect (
  .i_clk(i_clk), .i_rst_n(i_rst_n),
  .i_done_val(done_val), .o_done_rdy(done_rdy),
  .i_lane_res(lane_res), .i_lane_tag(lane_tag),
  .o_val(o_val), .i_rdy(i_rdy), .o_res(o_res), .o_tag(o_tag)
);

endmodule

// ==== sim/fe2_mul_engine_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the Fp2 multiplication engine
// random and edge jobs, reference model keyed by tag, output hold checks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fe2_mul_engine_tb;

import fe2_pkg::*;

localparam int NUM_LANES = 4;
localparam int MUL_LEVEL = 3;
localparam int TIMEOUT   = 2000;  // cycles per wait

logic        i_clk;
logic        i_rst_n;
logic        i_val;
logic        o_rdy;
fe2_t        i_a;
fe2_t        i_b;
tag_t        i_tag;
logic        o_val;
logic        i_rdy;
fe2_t        o_res;
tag_t        o_tag;

fe2_t        exp_res [tag_t];  // expected result of each job in flight
logic [31:0] lfsr_q;
int          errors;
int          timeouts;
int          sent;
int          received;
int          max_inflight;
bit          saw_full;         // job waiting with every lane busy
bit          rdy_random;
tag_t        next_tag;
bit          held;             // output stalled on the last edge
fe2_t        held_res;
tag_t        held_tag;

fe2_mul_engine #(.NUM_LANES(NUM_LANES), .MUL_LEVEL(MUL_LEVEL)) i_fe2_mul_engine (
  .i_clk(i_clk), .i_rst_n(i_rst_n),
  .i_val(i_val), .o_rdy(o_rdy), .i_a(i_a), .i_b(i_b), .i_tag(i_tag),
  .o_val(o_val), .i_rdy(i_rdy), .o_res(o_res), .o_tag(o_tag)
);

initial begin
  i_clk = 1'b0;
  forever #4 i_clk = ~i_clk;
end

// galois step for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

task automatic draw_bits(input int n, output logic [31:0] v);
  v = '0;
  for (int k = 0; k < n; k++) begin
    lfsr_q = lfsr_step(lfsr_q);
    v      = {v[30:0], lfsr_q[0]};
  end
endtask

// (a0 + a1 u)(b0 + b1 u) with u^2 = -1
function automatic fe2_t fp2_mul_model(fe2_t a, fe2_t b);
  fe_wide_t p00;
  fe_wide_t p11;
  fe_wide_t p01;
  fe_wide_t p10;
  fe_wide_t c0;
  fe_wide_t c1;
  p00 = (fe_wide_t'(a[31:0]) * fe_wide_t'(b[31:0])) % fe_wide_t'(P);
  p11 = (fe_wide_t'(a[63:32]) * fe_wide_t'(b[63:32])) % fe_wide_t'(P);
  p01 = (fe_wide_t'(a[31:0]) * fe_wide_t'(b[63:32])) % fe_wide_t'(P);
  p10 = (fe_wide_t'(a[63:32]) * fe_wide_t'(b[31:0])) % fe_wide_t'(P);
  c0  = (p00 + fe_wide_t'(P) - p11) % fe_wide_t'(P);
  c1  = (p01 + p10) % fe_wide_t'(P);
  return {c1[31:0], c0[31:0]};
endfunction

function automatic fe_t edge_value(int k);
  case (k)
    0:       return '0;
    1:       return 32'd1;
    default: return P - 32'd1;
  endcase
endfunction

task automatic send_job(input fe2_t a, input fe2_t b);
  bit taken;
  if (timeouts != 0) return;
  @(negedge i_clk);
  i_val = 1'b1;
  i_a   = a;
  i_b   = b;
  i_tag = next_tag;
  taken = 1'b0;
  for (int n = 0; n < TIMEOUT && !taken; n++) begin
    @(posedge i_clk);
    taken = o_rdy;
  end
  if (!taken) begin
    timeouts++;
    $display("%0t timeout, job with tag %0d was never accepted", $time, next_tag);
    return;
  end
  exp_res[next_tag] = fp2_mul_model(a, b);
  sent++;
  next_tag++;
endtask

task automatic send_random_job;
  logic [31:0] v [4];
  for (int k = 0; k < 4; k++) begin
    draw_bits(32, v[k]);
    if (v[k] >= P) v[k] = v[k] - P;  // keep operands below P
  end
  send_job({v[1], v[0]}, {v[3], v[2]});
endtask

task automatic stop_input;
  @(negedge i_clk);
  i_val = 1'b0;
endtask

task automatic drain_jobs;
  bit empty;
  if (timeouts != 0) return;
  empty = 1'b0;
  for (int n = 0; n < TIMEOUT && !empty; n++) begin
    @(negedge i_clk);
    empty = (exp_res.num() == 0);
  end
  if (!empty) begin
    timeouts++;
    $display("%0t timeout, %0d jobs never came back", $time, exp_res.num());
  end
endtask

// random back-pressure on the output
always @(negedge i_clk) begin
  logic [31:0] r;
  if (rdy_random) begin
    draw_bits(1, r);
    i_rdy = r[0];
  end else begin
    i_rdy = 1'b1;
  end
end

always @(negedge i_clk) begin
  if (sent - received > max_inflight) max_inflight = sent - received;
end

always @(posedge i_clk) begin
  if (i_rst_n) begin
    if (i_val && !o_rdy) saw_full = 1'b1;
    if (held) begin
      assert (o_res == held_res) else begin
        errors++;
        $display("[FAIL] %0t o_res expected %h got %h", $time, held_res, o_res);
      end
      assert (o_tag == held_tag) else begin
        errors++;
        $display("[FAIL] %0t o_tag expected %h got %h", $time, held_tag, o_tag);
      end
    end
    if (o_val && i_rdy) begin
      assert (exp_res.exists(o_tag)) else begin
        errors++;
        $display("%0t tag %0d came out but was not in flight", $time, o_tag);
      end
      if (exp_res.exists(o_tag)) begin
        assert (o_res == exp_res[o_tag]) else begin
          errors++;
          $display("[FAIL] %0t o_res (tag %0d) expected %h got %h",
                   $time, o_tag, exp_res[o_tag], o_res);
        end
        exp_res.delete(o_tag);
        received++;
      end
    end
    held     = o_val && !i_rdy;
    held_res = o_res;
    held_tag = o_tag;
  end
end

hold_val: assert property (@(posedge i_clk) disable iff (!i_rst_n)
  (o_val && !i_rdy) |=> o_val)
  else begin
    errors++;
    $display("%0t o_val dropped while the output was stalled", $time);
  end

res_reduced: assert property (@(posedge i_clk) disable iff (!i_rst_n)
  o_val |-> (o_res[31:0] < P) && (o_res[63:32] < P))
  else begin
    errors++;
    $display("[FAIL] %0t o_res halves expected below %h got %h", $time, P, $sampled(o_res));
  end

initial begin
  bit ok;
  i_rst_n      = 1'b0;
  i_val        = 1'b0;
  i_a          = '0;
  i_b          = '0;
  i_tag        = '0;
  i_rdy        = 1'b1;
  lfsr_q       = 32'h9573aea9;
  errors       = 0;
  timeouts     = 0;
  sent         = 0;
  received     = 0;
  max_inflight = 0;
  saw_full     = 1'b0;
  rdy_random   = 1'b0;
  next_tag     = '0;
  held         = 1'b0;
  repeat (2) @(posedge i_clk);
  @(negedge i_clk);
  i_rst_n = 1'b1;

  // idle after reset
  ok = 1'b0;
  for (int n = 0; n < 16 && !ok; n++) begin
    @(posedge i_clk);
    assert (!o_val) else begin
      errors++;
      $display("[FAIL] %0t o_val expected 0 got %b", $time, o_val);
    end
    ok = o_rdy;
  end
  if (!ok) begin
    timeouts++;
    $display("%0t o_rdy did not rise after reset", $time);
  end

  send_random_job();  // one job alone
  stop_input();
  drain_jobs();

  for (int j = 0; j < 40; j++) send_random_job();
  stop_input();
  drain_jobs();
  assert (max_inflight == NUM_LANES) else begin
    errors++;
    $display("[FAIL] %0t jobs in flight expected %0d got %0d", $time, NUM_LANES, max_inflight);
  end
  assert (saw_full) else begin
    errors++;
    $display("%0t o_rdy never fell with all lanes busy", $time);
  end

  @(posedge i_clk);
  rdy_random = 1'b1;
  for (int j = 0; j < 40; j++) send_random_job();
  stop_input();
  drain_jobs();
  @(posedge i_clk);
  rdy_random = 1'b0;

  // 0, 1 and P-1 in every half
  for (int k = 0; k < 81; k++) begin
    send_job({edge_value((k / 3) % 3), edge_value(k % 3)},
             {edge_value((k / 27) % 3), edge_value((k / 9) % 3)});
  end
  stop_input();
  drain_jobs();

  $display("jobs sent %0d received %0d, errors %0d, timeouts %0d",
           sent, received, errors, timeouts);
  if (errors == 0 && timeouts == 0) begin
    $display("ALL CHECKS PASSED");
  end else begin
    $display("CHECKS FAILED");
  end
  $finish;
end

endmodule

// ==== fe2_mul_engine.f ====
common/fe2_pkg.sv
design/mul_share/fe_mul_pipe.sv
design/mul_share/mul_share_arb.sv
design/fe2_dispatch.sv
design/fe2_mul_lane.sv
design/fe2_collect.sv
design/fe2_mul_engine.sv
sim/fe2_mul_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the Fp2 multiplication engine testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module fe2_mul_engine_tb \
  -f fe2_mul_engine.f \
  -o fe2_mul_engine_sim

# an aborted run counts as a failure too
if ! ./obj_dir/fe2_mul_engine_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulation aborted"
  exit 1
fi
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
